/* load_queue.f */
lq_pkg.sv
lq_ptr_ctrl.sv
lq_entry_table.sv
lq_wb_select.sv
lq_violation_check.sv
load_queue.sv
load_queue_tb.sv

/* Bender.yml */
package:
  name: load_queue

sources:
  - lq_pkg.sv
  - lq_ptr_ctrl.sv
  - lq_entry_table.sv
  - lq_wb_select.sv
  - lq_violation_check.sv
  - load_queue.sv
  - target: test
    files:
      - load_queue_tb.sv

/* load_queue_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module load_queue_tb import lq_pkg::*; ();

    localparam int TIMEOUT = 64; // Cycles per bounded wait.

    logic          clk = 1'b0;
    logic          rst;
    logic          alloc_valid;
    lq_alloc_t     alloc;
    logic          alloc_ready;
    lq_ptr_t       alloc_ptr;
    logic          issue_valid;
    lq_issue_t     issue;
    logic          refill_valid;
    lq_refill_t    refill;
    logic          commit_valid;
    logic          wb_valid;
    lq_wb_t        wb;
    logic          wb_ready;
    logic          st_valid;
    st_check_t     st;
    logic          viol_valid;
    lq_violation_t viol;

    int alloc_count; // Allocations since the last reset.

    always #4 clk = ~clk;

    load_queue load_queue_i (
        .clk          (clk),
        .rst          (rst),
        .alloc_valid  (alloc_valid),
        .alloc        (alloc),
        .alloc_ready  (alloc_ready),
        .alloc_ptr    (alloc_ptr),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .refill_valid (refill_valid),
        .refill       (refill),
        .commit_valid (commit_valid),
        .wb_valid     (wb_valid),
        .wb           (wb),
        .wb_ready     (wb_ready),
        .st_valid     (st_valid),
        .st           (st),
        .viol_valid   (viol_valid),
        .viol         (viol)
    );

    // ********************
    // Compare tasks
    // ********************

    task automatic stop_run;
        $display("SOME TESTS FAILED");
        $fatal(1, "Stopped at first error.");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_ptr(input string name, input lq_ptr_t got, input lq_ptr_t exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_wb(input string name, input lq_wb_t got, input lq_wb_t exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_viol(input string name, input lq_violation_t got,
                              input lq_violation_t exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            stop_run();
        end
    endtask

    // ********************
    // Reference model
    // ********************

    function automatic lq_issue_t make_load(input lq_ptr_t ptr, input paddr_t paddr,
                                            input ld_size_t size, input logic uext,
                                            input logic miss, input byte_mask_t fwd_mask,
                                            input word_t fwd_data);
        lq_issue_t ld;
        ld.ptr      = ptr;
        ld.paddr    = paddr;
        ld.size     = size;
        ld.uext     = uext;
        ld.mask     = byte_mask_t'(((1 << (1 << size)) - 1) << paddr[2:0]);
        ld.miss     = miss;
        ld.fwd_mask = fwd_mask;
        ld.fwd_data = fwd_data;
        return ld;
    endfunction

    // Forwarded bytes win, then align, cut and extend.
    function automatic word_t expected_load_data(input lq_issue_t ld, input word_t fill);
        logic [7:0] bytes [8];
        word_t      res;
        int         off;
        int         nbytes;
        logic       sign;
        off    = ld.paddr[2:0];
        nbytes = 1 << ld.size;
        res    = '0;
        for (int b = 0; b < 8; b++) begin
            bytes[b] = ld.fwd_mask[b] ? ld.fwd_data[8*b +: 8] : fill[8*b +: 8];
        end
        for (int k = 0; k < nbytes; k++) begin
            if (off + k < 8) begin
                res[8*k +: 8] = bytes[off + k];
            end
        end
        sign = ~ld.uext & res[8*nbytes - 1];
        for (int k = nbytes; k < 8; k++) begin
            res[8*k +: 8] = {8{sign}};
        end
        return res;
    endfunction

    // ********************
    // Drivers
    // ********************

    task automatic step;
        @(posedge clk);
        #1;
    endtask

    task automatic reset_dut;
        rst = 1'b1;
        alloc_count = 0;
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;
    endtask

    task automatic alloc_load(input rob_idx_t rob, input preg_t rd, output lq_ptr_t ptr);
        int n;
        ptr         = lq_ptr_t'(alloc_count[3:0]); // Tail counts allocations mod 16.
        alloc_valid = 1'b1;
        alloc.rob_idx = rob;
        alloc.rd      = rd;
        n = 0;
        @(negedge clk);
        while (alloc_ready !== 1'b1) begin
            n++;
            if (n > TIMEOUT) begin
                $display("Timed out waiting for alloc_ready.");
                stop_run();
            end
            @(negedge clk);
        end
        check_ptr("alloc_ptr", alloc_ptr, ptr);
        step();
        alloc_valid = 1'b0;
        alloc_count++;
    endtask

    task automatic issue_load(input lq_issue_t ld);
        issue_valid = 1'b1;
        issue       = ld;
        step();
        issue_valid = 1'b0;
    endtask

    task automatic refill_load(input lq_idx_t idx, input word_t data);
        refill_valid = 1'b1;
        refill.idx   = idx;
        refill.data  = data;
        step();
        refill_valid = 1'b0;
    endtask

    task automatic commit_one;
        commit_valid = 1'b1;
        step();
        commit_valid = 1'b0;
    endtask

    task automatic wait_wb_valid;
        int n;
        n = 0;
        @(negedge clk);
        while (wb_valid !== 1'b1) begin
            n++;
            if (n > TIMEOUT) begin
                $display("Timed out waiting for wb_valid.");
                stop_run();
            end
            @(negedge clk);
        end
    endtask

    // Report lands exactly one edge later, for one cycle.
    task automatic store_check(input st_check_t s, input logic exp_hit,
                               input lq_violation_t exp);
        st_valid = 1'b1;
        st       = s;
        step();
        st_valid = 1'b0;
        @(negedge clk);
        check_bit("viol_valid", viol_valid, exp_hit);
        if (exp_hit) begin
            check_viol("viol", viol, exp);
        end
        step();
        @(negedge clk);
        check_bit("viol_valid", viol_valid, 1'b0);
        step();
    endtask

    // ********************
    // Tests
    // ********************

    task automatic alloc_and_full;
        lq_ptr_t ptr;
        reset_dut();
        @(negedge clk);
        check_bit("alloc_ready", alloc_ready, 1'b1);
        check_bit("wb_valid", wb_valid, 1'b0);
        check_bit("viol_valid", viol_valid, 1'b0);
        step();
        for (int k = 0; k < 8; k++) begin
            alloc_load(rob_idx_t'(k), preg_t'(k), ptr);
        end
        @(negedge clk);
        check_bit("alloc_ready", alloc_ready, 1'b0);
        step();
        commit_one();
        @(negedge clk);
        check_bit("alloc_ready", alloc_ready, 1'b1);
        check_ptr("alloc_ptr", alloc_ptr, lq_ptr_t'(4'b1000));
        step();
    endtask

    task automatic hit_load;
        lq_ptr_t       ptr;
        st_check_t     s;
        lq_violation_t exp;
        reset_dut();
        alloc_load(6'd5, 6'd9, ptr);
        issue_load(make_load(ptr, 32'h2000, LD_W, 1'b0, 1'b0, '0, '0));
        repeat (4) begin
            @(negedge clk);
            check_bit("wb_valid", wb_valid, 1'b0);
            step();
        end
        s.ptr   = ptr;
        s.paddr = 32'h2000;
        s.mask  = 8'h0f;
        exp.ptr     = ptr;
        exp.rob_idx = 6'd5;
        store_check(s, 1'b1, exp);
        commit_one();
        store_check(s, 1'b0, exp); // Freed entry no longer matches.
    endtask

    task automatic miss_refill_sizes;
        lq_ptr_t   ptr;
        lq_issue_t ld;
        lq_wb_t    exp;
        paddr_t    addr;
        word_t     fill;
        int        off;
        reset_dut();
        for (int s = 0; s < 4; s++) begin
            for (int u = 0; u < 2; u++) begin
                off  = ($urandom % 8) & ~((1 << s) - 1);
                addr = $urandom;
                addr[2:0]   = off[2:0];
                exp.rob_idx = rob_idx_t'(s*2 + u + 1);
                exp.rd      = preg_t'(32 + s*2 + u);
                alloc_load(exp.rob_idx, exp.rd, ptr);
                ld = make_load(ptr, addr, ld_size_t'(s), u[0], 1'b1,
                               byte_mask_t'($urandom), {$urandom, $urandom});
                issue_load(ld);
                fill = {$urandom, $urandom};
                refill_load(ptr.idx, fill);
                exp.data = expected_load_data(ld, fill);
                wait_wb_valid();
                check_wb("wb", wb, exp);
                repeat (3) begin // Stalled writeback holds.
                    step();
                    @(negedge clk);
                    check_bit("wb_valid", wb_valid, 1'b1);
                    check_wb("wb", wb, exp);
                end
                step();
                wb_ready = 1'b1;
                step();
                wb_ready = 1'b0;
                @(negedge clk);
                check_bit("wb_valid", wb_valid, 1'b0);
                step();
                commit_one();
            end
        end
    endtask

    task automatic refill_burst;
        lq_issue_t loads [6];
        word_t     fills [6];
        lq_ptr_t   ptr;
        lq_wb_t    exp;
        reset_dut();
        for (int k = 0; k < 6; k++) begin
            alloc_load(rob_idx_t'(10 + k), preg_t'(20 + k), ptr);
            loads[k] = make_load(ptr, paddr_t'(32'h1000 + 8*k), LD_D, 1'b0, 1'b1,
                                 byte_mask_t'($urandom), {$urandom, $urandom});
        end
        for (int k = 0; k < 6; k++) begin
            issue_load(loads[k]);
        end
        for (int k = 0; k < 6; k++) begin
            fills[k] = {$urandom, $urandom};
            refill_load(loads[k].ptr.idx, fills[k]);
        end
        wb_ready = 1'b1;
        for (int k = 0; k < 6; k++) begin
            wait_wb_valid();
            exp.rob_idx = rob_idx_t'(10 + k);
            exp.rd      = preg_t'(20 + k);
            exp.data    = expected_load_data(loads[k], fills[k]);
            check_wb("wb", wb, exp);
            step();
        end
        wb_ready = 1'b0;
        repeat (4) begin // Nothing left over.
            @(negedge clk);
            check_bit("wb_valid", wb_valid, 1'b0);
            step();
        end
    endtask

    task automatic store_violation;
        lq_ptr_t       p [4];
        st_check_t     s;
        lq_violation_t exp;
        reset_dut();
        for (int k = 0; k < 4; k++) begin
            alloc_load(rob_idx_t'(20 + k), preg_t'(k), p[k]);
        end
        issue_load(make_load(p[0], 32'h3a40, LD_D, 1'b0, 1'b0, '0, '0));
        issue_load(make_load(p[1], 32'h3a40, LD_W, 1'b0, 1'b0, '0, '0));
        issue_load(make_load(p[2], 32'h3a44, LD_H, 1'b0, 1'b0, '0, '0));
        s.ptr   = p[1];
        s.paddr = 32'h3a40;
        s.mask  = 8'hff;
        exp.ptr     = p[1];
        exp.rob_idx = 6'd21;
        store_check(s, 1'b1, exp);
        s.mask      = 8'h20;
        exp.ptr     = p[2];
        exp.rob_idx = 6'd22;
        store_check(s, 1'b1, exp);
        s.mask = 8'hc0;
        store_check(s, 1'b0, exp);
        s.mask  = 8'hff;
        s.paddr = 32'h3a48;
        store_check(s, 1'b0, exp);
        s.paddr = 32'h3a40;
        s.ptr   = lq_ptr_t'(4'd4); // All loads older.
        store_check(s, 1'b0, exp);
    endtask

    task automatic wraparound_violation;
        lq_ptr_t       ptr;
        lq_ptr_t       q [5];
        st_check_t     s;
        lq_violation_t exp;
        reset_dut();
        for (int k = 0; k < 6; k++) begin
            alloc_load(rob_idx_t'(40 + k), preg_t'(k), ptr);
        end
        repeat (6) commit_one();
        for (int j = 0; j < 5; j++) begin
            alloc_load(rob_idx_t'(46 + j), preg_t'(j), q[j]);
        end
        issue_load(make_load(q[0], 32'h7f80, LD_D, 1'b0, 1'b0, '0, '0));
        issue_load(make_load(q[1], 32'h7f80, LD_W, 1'b0, 1'b0, '0, '0));
        issue_load(make_load(q[2], 32'h7f84, LD_W, 1'b0, 1'b0, '0, '0));
        issue_load(make_load(q[3], 32'h7f84, LD_W, 1'b0, 1'b0, '0, '0));
        s.ptr   = q[1];
        s.paddr = 32'h7f80;
        s.mask  = 8'hff;
        exp.ptr     = q[1];
        exp.rob_idx = 6'd47;
        store_check(s, 1'b1, exp);
        s.mask      = 8'hf0; // Only the wrapped loads overlap.
        exp.ptr     = q[2];
        exp.rob_idx = 6'd48;
        store_check(s, 1'b1, exp);
        s.ptr       = q[3];
        s.mask      = 8'hff;
        exp.ptr     = q[3];
        exp.rob_idx = 6'd49;
        store_check(s, 1'b1, exp);
    endtask

    initial begin
        void'($urandom(32'h7e0));
        alloc_count  = 0;
        rst          = 1'b1;
        alloc_valid  = 1'b0;
        alloc        = '0;
        issue_valid  = 1'b0;
        issue        = '0;
        refill_valid = 1'b0;
        refill       = '0;
        commit_valid = 1'b0;
        wb_ready     = 1'b0;
        st_valid     = 1'b0;
        st           = '0;
        alloc_and_full();
        hit_load();
        miss_refill_sizes();
        refill_burst();
        store_violation();
        wraparound_violation();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* load_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module load_queue import lq_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       alloc_valid,
    input  wire lq_alloc_t  alloc,
    output logic            alloc_ready,
    output lq_ptr_t         alloc_ptr,
    input  wire logic       issue_valid,
    input  wire lq_issue_t  issue,
    input  wire logic       refill_valid,
    input  wire lq_refill_t refill,
    input  wire logic       commit_valid,
    output logic            wb_valid,
    output lq_wb_t          wb,
    input  wire logic       wb_ready,
    input  wire logic       st_valid,
    input  wire st_check_t  st,
    output logic            viol_valid,
    output lq_violation_t   viol
);

    logic               alloc_fire;
    lq_ptr_t            head;
    lq_ptr_t            tail;
    logic [LQ_SIZE-1:0] waiting;
    logic [LQ_SIZE-1:0] addr_valid;
    logic [LQ_SIZE-1:0] valid;
    lq_wb_t             wb_entry;
    lq_idx_t            wb_idx;
    logic               wb_fire;
    paddr_t             entry_paddr [LQ_SIZE];
    byte_mask_t         entry_mask [LQ_SIZE];
    rob_idx_t           entry_rob [LQ_SIZE];

    assign alloc_fire = alloc_valid & alloc_ready;

    lq_ptr_ctrl lq_ptr_ctrl_i (
        .clk          (clk),
        .rst          (rst),
        .alloc_valid  (alloc_valid),
        .alloc_ready  (alloc_ready),
        .alloc_ptr    (alloc_ptr),
        .commit_valid (commit_valid),
        .head         (head),
        .tail         (tail)
    );

    lq_entry_table lq_entry_table_i (
        .clk          (clk),
        .rst          (rst),
        .alloc_fire   (alloc_fire),
        .alloc_ptr    (alloc_ptr),
        .alloc        (alloc),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .refill_valid (refill_valid),
        .refill       (refill),
        .commit_valid (commit_valid),
        .head         (head),
        .wb_idx       (wb_idx),
        .wb_fire      (wb_fire),
        .waiting      (waiting),
        .addr_valid   (addr_valid),
        .valid        (valid),
        .wb_entry     (wb_entry),
        .entry_paddr  (entry_paddr),
        .entry_mask   (entry_mask),
        .entry_rob    (entry_rob)
    );

    lq_wb_select lq_wb_select_i (
        .clk      (clk),
        .rst      (rst),
        .waiting  (waiting),
        .wb_entry (wb_entry),
        .wb_idx   (wb_idx),
        .wb_fire  (wb_fire),
        .wb_valid (wb_valid),
        .wb       (wb),
        .wb_ready (wb_ready)
    );

    lq_violation_check lq_violation_check_i (
        .clk         (clk),
        .rst         (rst),
        .st_valid    (st_valid),
        .st          (st),
        .valid       (valid),
        .addr_valid  (addr_valid),
        .tail        (tail),
        .entry_paddr (entry_paddr),
        .entry_mask  (entry_mask),
        .entry_rob   (entry_rob),
        .viol_valid  (viol_valid),
        .viol        (viol)
    );

endmodule

`default_nettype wire

/* lq_violation_check.sv */
`timescale 1ns/1ps
`default_nettype none

module lq_violation_check import lq_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire logic      st_valid,
    input  wire st_check_t st,
    input  wire logic [LQ_SIZE-1:0] valid,
    input  wire logic [LQ_SIZE-1:0] addr_valid,
    input  wire lq_ptr_t   tail,
    input  wire paddr_t    entry_paddr [LQ_SIZE],
    input  wire byte_mask_t entry_mask [LQ_SIZE],
    input  wire rob_idx_t  entry_rob [LQ_SIZE],
    output logic          viol_valid,
    output lq_violation_t viol
);

    logic               wrapped;
    logic [LQ_SIZE-1:0] age_mask;
    logic [LQ_SIZE-1:0] hit;
    logic [LQ_SIZE-1:0] hit_hi;
    logic [LQ_SIZE-1:0] hit_lo;
    lq_idx_t            sel_idx;
    lq_ptr_t            sel_ptr;

    // Store and tail on different laps.
    assign wrapped = st.ptr.dir != tail.dir;

    always_comb begin
        for (int i = 0; i < LQ_SIZE; i++) begin
            if (wrapped) begin
                age_mask[i] = (i >= st.ptr.idx) || (i < tail.idx);
            end else begin
                age_mask[i] = (i >= st.ptr.idx) && (i < tail.idx);
            end
            hit[i] = st_valid & valid[i] & addr_valid[i] & age_mask[i]
                     & (entry_paddr[i][$bits(paddr_t)-1:OFFSET_W]
                        == st.paddr[$bits(paddr_t)-1:OFFSET_W])
                     & (|(entry_mask[i] & st.mask));
            hit_hi[i] = hit[i] & (i >= st.ptr.idx);
        end
        hit_lo = hit & ~hit_hi; // Younger loads below the store index.
    end

    // ********************
    // Oldest match
    // ********************

    always_comb begin
        if (|hit_hi) begin
            sel_idx     = prio_lowest(hit_hi);
            sel_ptr.dir = st.ptr.dir;
        end else begin
            sel_idx     = prio_lowest(hit_lo);
            sel_ptr.dir = ~st.ptr.dir;
        end
        sel_ptr.idx = sel_idx;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            viol_valid <= 1'b0;
        end else begin
            viol_valid <= |hit; // One-cycle pulse.
        end
    end

    always_ff @(posedge clk) begin
        viol.ptr     <= sel_ptr;
        viol.rob_idx <= entry_rob[sel_idx];
    end

endmodule

`default_nettype wire

/* lq_wb_select.sv */
`timescale 1ns/1ps
`default_nettype none

module lq_wb_select import lq_pkg::*; (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic [LQ_SIZE-1:0] waiting,
    input  wire lq_wb_t wb_entry,
    output lq_idx_t   wb_idx,
    output logic      wb_fire,
    output logic      wb_valid,
    output lq_wb_t    wb,
    input  wire logic wb_ready
);

    typedef enum logic {
        WB_IDLE,
        WB_HOLD
    } wb_state_t;

    wb_state_t state;
    lq_idx_t   idx_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= WB_IDLE;
            idx_q <= '0;
        end else begin
            case (state)
                WB_IDLE: begin
                    if (|waiting) begin
                        idx_q <= prio_lowest(waiting); // Lowest index first.
                        state <= WB_HOLD;
                    end
                end
                WB_HOLD: begin
                    if (wb_ready) begin
                        state <= WB_IDLE;
                    end
                end
                default: state <= WB_IDLE;
            endcase
        end
    end

    // Payload holds while the index is latched.
    assign wb_idx   = idx_q;
    assign wb_valid = (state == WB_HOLD);
    assign wb_fire  = wb_valid & wb_ready;
    assign wb       = wb_entry;

endmodule

`default_nettype wire

/* lq_entry_table.sv */
`timescale 1ns/1ps
`default_nettype none

module lq_entry_table import lq_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       alloc_fire,
    input  wire lq_ptr_t    alloc_ptr,
    input  wire lq_alloc_t  alloc,
    input  wire logic       issue_valid,
    input  wire lq_issue_t  issue,
    input  wire logic       refill_valid,
    input  wire lq_refill_t refill,
    input  wire logic       commit_valid,
    input  wire lq_ptr_t    head,
    input  wire lq_idx_t    wb_idx,
    input  wire logic       wb_fire,
    output logic [LQ_SIZE-1:0] waiting,
    output logic [LQ_SIZE-1:0] addr_valid,
    output logic [LQ_SIZE-1:0] valid,
    output lq_wb_t          wb_entry,
    output paddr_t          entry_paddr [LQ_SIZE],
    output byte_mask_t      entry_mask [LQ_SIZE],
    output rob_idx_t        entry_rob [LQ_SIZE]
);

    logic [LQ_SIZE-1:0] miss;
    logic [LQ_SIZE-1:0] data_valid;
    logic [LQ_SIZE-1:0] written_back;

    preg_t              rd_q [LQ_SIZE];
    ld_size_t           size_q [LQ_SIZE];
    logic [LQ_SIZE-1:0] uext_q;
    byte_mask_t         fwd_mask_q [LQ_SIZE];
    word_t              fwd_data_q [LQ_SIZE];
    word_t              data_q [LQ_SIZE];

    word_t merged;
    word_t shifted;
    word_t ext_data;

    // ********************
    // Refill merge and align
    // ********************

    always_comb begin
        for (int b = 0; b < 8; b++) begin
            merged[b*8 +: 8] = fwd_mask_q[refill.idx][b] ? fwd_data_q[refill.idx][b*8 +: 8]
                                                         : refill.data[b*8 +: 8];
        end
        shifted = merged >> {entry_paddr[refill.idx][OFFSET_W-1:0], 3'b000};
        case (size_q[refill.idx])
            LD_B:    ext_data = {{56{~uext_q[refill.idx] & shifted[7]}}, shifted[7:0]};
            LD_H:    ext_data = {{48{~uext_q[refill.idx] & shifted[15]}}, shifted[15:0]};
            LD_W:    ext_data = {{32{~uext_q[refill.idx] & shifted[31]}}, shifted[31:0]};
            default: ext_data = shifted;
        endcase
    end

    // ********************
    // Status bits
    // ********************

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid        <= '0;
            miss         <= '0;
            addr_valid   <= '0;
            data_valid   <= '0;
            written_back <= '0;
        end else begin
            if (alloc_fire) begin
                valid[alloc_ptr.idx]        <= 1'b1;
                miss[alloc_ptr.idx]         <= 1'b0;
                addr_valid[alloc_ptr.idx]   <= 1'b0;
                data_valid[alloc_ptr.idx]   <= 1'b0;
                written_back[alloc_ptr.idx] <= 1'b0;
            end
            if (issue_valid) begin
                addr_valid[issue.ptr.idx]   <= 1'b1;
                miss[issue.ptr.idx]         <= issue.miss;
                data_valid[issue.ptr.idx]   <= ~issue.miss;
                written_back[issue.ptr.idx] <= ~issue.miss; // Hits leave via the pipeline.
            end
            if (refill_valid) begin
                data_valid[refill.idx] <= 1'b1;
            end
            if (wb_fire) begin
                written_back[wb_idx] <= 1'b1;
            end
            if (commit_valid) begin
                valid[head.idx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            entry_rob[alloc_ptr.idx] <= alloc.rob_idx;
            rd_q[alloc_ptr.idx]      <= alloc.rd;
        end
        if (issue_valid) begin
            entry_paddr[issue.ptr.idx] <= issue.paddr;
            entry_mask[issue.ptr.idx]  <= issue.mask;
            size_q[issue.ptr.idx]      <= issue.size;
            uext_q[issue.ptr.idx]      <= issue.uext;
            fwd_mask_q[issue.ptr.idx]  <= issue.fwd_mask;
            fwd_data_q[issue.ptr.idx]  <= issue.fwd_data;
        end
        if (refill_valid) begin
            data_q[refill.idx] <= ext_data;
        end
    end

    assign waiting = valid & miss & data_valid & ~written_back;

    assign wb_entry.rob_idx = entry_rob[wb_idx];
    assign wb_entry.rd      = rd_q[wb_idx];
    assign wb_entry.data    = data_q[wb_idx];

endmodule

`default_nettype wire

/* lq_ptr_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module lq_ptr_ctrl import lq_pkg::*; (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic alloc_valid,
    output logic      alloc_ready,
    output lq_ptr_t   alloc_ptr,
    input  wire logic commit_valid,
    output lq_ptr_t   head,
    output lq_ptr_t   tail
);

    logic    full;
    lq_ptr_t head_next;
    lq_ptr_t tail_next;

    // Same slot on the other lap.
    assign full = (head.idx == tail.idx) && (head.dir != tail.dir);

    assign alloc_ready = ~full;
    assign alloc_ptr   = tail;

    // Carry out of idx flips dir.
    assign head_next = lq_ptr_t'(head + 4'd1);
    assign tail_next = lq_ptr_t'(tail + 4'd1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (alloc_valid && alloc_ready) begin
                tail <= tail_next;
            end
            if (commit_valid) begin
                head <= head_next; // Commit frees oldest.
            end
        end
    end

endmodule

`default_nettype wire

/* lq_pkg.sv */
`default_nettype none

package lq_pkg;

    localparam int LQ_SIZE = 8;
    localparam int LQ_IDX_W = 3;
    localparam int OFFSET_W = 3; // Byte offset within a word.

    typedef logic [LQ_IDX_W-1:0] lq_idx_t;
    typedef logic [5:0]          rob_idx_t;
    typedef logic [5:0]          preg_t;
    typedef logic [31:0]         paddr_t;
    typedef logic [63:0]         word_t;
    typedef logic [7:0]          byte_mask_t;

    typedef enum logic [1:0] {
        LD_B = 2'd0,
        LD_H = 2'd1,
        LD_W = 2'd2,
        LD_D = 2'd3
    } ld_size_t;

    // Wrap bit plus index gives program order age.
    typedef struct packed {
        logic    dir;
        lq_idx_t idx;
    } lq_ptr_t;

    // ********************
    // Port payloads
    // ********************

    typedef struct packed {
        rob_idx_t rob_idx;
        preg_t    rd;
    } lq_alloc_t;

    typedef struct packed {
        lq_ptr_t    ptr;
        paddr_t     paddr;
        ld_size_t   size;
        logic       uext;
        byte_mask_t mask;     // Bytes read by the load.
        logic       miss;
        byte_mask_t fwd_mask; // Bytes supplied by store forwarding.
        word_t      fwd_data;
    } lq_issue_t;

    typedef struct packed {
        lq_idx_t idx;
        word_t   data;
    } lq_refill_t;

    typedef struct packed {
        rob_idx_t rob_idx;
        preg_t    rd;
        word_t    data;
    } lq_wb_t;

    typedef struct packed {
        lq_ptr_t    ptr;  // First load younger than the store.
        paddr_t     paddr;
        byte_mask_t mask;
    } st_check_t;

    typedef struct packed {
        lq_ptr_t  ptr;
        rob_idx_t rob_idx;
    } lq_violation_t;

    // Lowest set bit wins.
    function automatic lq_idx_t prio_lowest(input logic [LQ_SIZE-1:0] vec);
        lq_idx_t idx;
        idx = '0;
        for (int i = LQ_SIZE - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = lq_idx_t'(i);
            end
        end
        return idx;
    endfunction

endpackage

`default_nettype wire
